//--- project.f
source/dcache_pkg.sv
source/lsu_m1_stage.sv
source/lsu_m2_stage.sv
source/dcache_manager.sv
source/apb_mem_requester.sv
source/dcache_top.sv
test/tb_apb_mem.sv
test/tb_dcache.sv

//--- test/tb_dcache.sv
// testbench for the data cache top level
// directed miss, hit and store cases, then a random load/store stream
// responses and APB traffic are checked by concurrent assertions
module tb_dcache;
  import dcache_pkg::*;

  localparam int          IDX_LEN      = 4;
  localparam int          MEM_WORDS    = 256;
  localparam int          RANDOM_OPS   = 300;
  localparam int          REQ_TIMEOUT  = 200;
  localparam int          IDLE_TIMEOUT = 2000;
  localparam logic [31:0] SEED         = 32'hff06_082c;

  logic clk;
  logic rst_n;
  cpu_req_t cpu_req;
  logic cpu_ready;
  cpu_rsp_t cpu_rsp;
  logic psel;
  logic penable;
  logic pwrite;
  logic pready;
  logic [31:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic [3:0] pstrb;

  int errors = 0;
  int seed;
  int rsp_count = 0;
  int reset_cycles = 0;
  logic [31:0] ref_mem [MEM_WORDS];

  // expected responses in request order
  logic [31:0] exp_fifo [1024];
  int wr_ptr = 0;
  int rd_ptr = 0;
  int exp_cnt;
  logic [31:0] exp_head;

  // directed checks, switched on per phase
  logic hit_mode;
  logic fill_mode;
  logic store_mode;
  logic [31:0] chk_addr;
  logic [31:0] chk_data;
  logic [3:0] chk_strb;
  int xfer_cnt = 0;
  int xfer_base;
  int xfer_idx;
  logic [31:0] fill_addr;
  logic accept;
  logic xfer;

  dcache_top #(
    .IDX_LEN(IDX_LEN)
  ) i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .cpu_req_i  (cpu_req),
    .cpu_ready_o(cpu_ready),
    .cpu_rsp_o  (cpu_rsp),
    .psel_o     (psel),
    .penable_o  (penable),
    .pwrite_o   (pwrite),
    .paddr_o    (paddr),
    .pwdata_o   (pwdata),
    .pstrb_o    (pstrb),
    .pready_i   (pready),
    .prdata_i   (prdata)
  );

  tb_apb_mem #(
    .WORDS(MEM_WORDS),
    .SEED (SEED)
  ) i_mem (
    .clk      (clk),
    .psel_i   (psel),
    .penable_i(penable),
    .pwrite_i (pwrite),
    .paddr_i  (paddr),
    .pwdata_i (pwdata),
    .pstrb_i  (pstrb),
    .pready_o (pready),
    .prdata_o (prdata)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  assign accept = cpu_req.valid && cpu_ready;
  assign xfer = psel && penable && pready;
  assign exp_cnt = wr_ptr - rd_ptr;
  assign exp_head = exp_fifo[rd_ptr];
  assign xfer_idx = xfer_cnt - xfer_base;
  assign fill_addr = {chk_addr[31:4], xfer_idx[1:0], 2'b00};

  always @(posedge clk) begin
    if (!rst_n) begin
      reset_cycles <= reset_cycles + 1;
    end
    if (rst_n && cpu_rsp.valid && exp_cnt > 0) begin
      rd_ptr <= rd_ptr + 1;
      rsp_count <= rsp_count + 1;
    end
    if (xfer) begin
      xfer_cnt <= xfer_cnt + 1;
    end
  end

  // registers are settled from the second reset edge on
  reset_quiet_a: assert property (@(posedge clk)
    !rst_n && reset_cycles > 0 |-> !psel && !penable && !cpu_rsp.valid && cpu_ready)
    else begin
      errors++;
      $display("APB or response activity, or ready low, during reset");
    end

  after_reset_a: assert property (@(posedge clk)
    $rose(rst_n) |-> cpu_ready && !psel && !penable && !cpu_rsp.valid)
    else begin
      errors++;
      $display("outputs not in their idle values when reset was released");
    end

  rsp_expected_a: assert property (@(posedge clk) disable iff (!rst_n)
    cpu_rsp.valid |-> exp_cnt > 0)
    else begin
      errors++;
      $display("response arrived with no request outstanding");
    end

  rsp_data_a: assert property (@(posedge clk) disable iff (!rst_n)
    cpu_rsp.valid && exp_cnt > 0 |-> cpu_rsp.rdata == exp_head)
    else begin
      errors++;
      $display("FAILED cpu_rsp.rdata exp %h got %h",
               $sampled(exp_head), $sampled(cpu_rsp.rdata));
    end

  hit_timing_a: assert property (@(posedge clk) disable iff (!rst_n)
    accept && hit_mode |=> ##1 cpu_rsp.valid)
    else begin
      errors++;
      $display("load hit response missing in the cycle after the next edge");
    end

  hit_no_apb_a: assert property (@(posedge clk) disable iff (!rst_n)
    accept && hit_mode |=> !psel [*2])
    else begin
      errors++;
      $display("APB activity during a load hit");
    end

  fill_addr_a: assert property (@(posedge clk) disable iff (!rst_n)
    xfer && fill_mode |-> !pwrite && xfer_idx < 4 && paddr == fill_addr)
    else begin
      errors++;
      $display("FAILED refill paddr exp %h got %h", $sampled(fill_addr), $sampled(paddr));
    end

  store_write_a: assert property (@(posedge clk) disable iff (!rst_n)
    xfer && pwrite && store_mode |->
      paddr == chk_addr && pwdata == chk_data && pstrb == chk_strb)
    else begin
      errors++;
      $display("FAILED apb write addr/data/strb exp %h/%h/%h got %h/%h/%h",
               $sampled(chk_addr), $sampled(chk_data), $sampled(chk_strb),
               $sampled(paddr), $sampled(pwdata), $sampled(pstrb));
    end

  setup_to_access_a: assert property (@(posedge clk) disable iff (!rst_n)
    psel && !penable |=> psel && penable && $stable(paddr) && $stable(pwrite))
    else begin
      errors++;
      $display("APB setup phase not followed by a stable access phase");
    end

  access_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    psel && penable && !pready |=> psel && penable && $stable(paddr) &&
      $stable(pwrite) && $stable(pwdata) && $stable(pstrb))
    else begin
      errors++;
      $display("APB access phase changed before pready");
    end

  enable_needs_sel_a: assert property (@(posedge clk) disable iff (!rst_n)
    penable |-> psel)
    else begin
      errors++;
      $display("penable high without psel");
    end

  idle_after_xfer_a: assert property (@(posedge clk) disable iff (!rst_n)
    xfer |=> !psel)
    else begin
      errors++;
      $display("no idle cycle after an APB transfer");
    end

  function automatic logic [31:0] apply_strobe(input logic [31:0] old_w,
                                               input logic [31:0] new_w,
                                               input logic [3:0]  strb);
    logic [31:0] mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (new_w & mask) | (old_w & ~mask);
  endfunction

  task automatic end_run();
    $display("responses checked: %0d, errors: %0d", rsp_count, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  task automatic abort_on_timeout(input string what);
    errors++;
    $display("timeout while waiting for %s", what);
    end_run();
  endtask

  // called one unit after a rising edge, returns at the same point
  task automatic issue_req(input logic write, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [3:0] strb);
    int waited;
    int idx;
    waited = 0;
    idx = addr[9:2];
    cpu_req.valid = 1'b1;
    cpu_req.write = write;
    cpu_req.addr = addr;
    cpu_req.wdata = wdata;
    cpu_req.strb = strb;
    @(negedge clk);
    while (!cpu_ready) begin
      waited++;
      if (waited > REQ_TIMEOUT) begin
        abort_on_timeout("request acceptance");
      end
      @(negedge clk);
    end
    // taken at the coming edge, in program order
    if (write) begin
      ref_mem[idx] = apply_strobe(ref_mem[idx], wdata, strb);
      exp_fifo[wr_ptr] = '0;
    end else begin
      exp_fifo[wr_ptr] = ref_mem[idx];
    end
    wr_ptr++;
    @(posedge clk);
    #1;
    cpu_req.valid = 1'b0;
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (exp_cnt != 0) begin
      waited++;
      if (waited > IDLE_TIMEOUT) begin
        abort_on_timeout("outstanding responses");
      end
      @(posedge clk);
      #1;
    end
  endtask

  task automatic check_xfers(input int expected, input string what);
    xfer_count_a: assert (xfer_cnt - xfer_base == expected)
      else begin
        errors++;
        $display("FAILED %s apb transfer count exp %h got %h",
                 what, expected, xfer_cnt - xfer_base);
      end
  endtask

  initial begin
    logic [31:0] rnd;
    logic [31:0] ctl;
    logic [31:0] addr;
    seed = SEED;
    rst_n = 1'b0;
    cpu_req = '0;
    hit_mode = 1'b0;
    fill_mode = 1'b0;
    store_mode = 1'b0;
    chk_addr = '0;
    chk_data = '0;
    chk_strb = '0;
    xfer_base = 0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int i = 0; i < MEM_WORDS; i++) begin
      ref_mem[i] = i_mem.mem[i];
    end

    // cold miss on an untouched line
    chk_addr = 32'h0000_0124;
    xfer_base = xfer_cnt;
    fill_mode = 1'b1;
    issue_req(1'b0, chk_addr, '0, '0);
    wait_drained();
    fill_mode = 1'b0;
    check_xfers(4, "refill");

    // same line again, two hits
    hit_mode = 1'b1;
    xfer_base = xfer_cnt;
    issue_req(1'b0, chk_addr, '0, '0);
    wait_drained();
    issue_req(1'b0, chk_addr + 32'd4, '0, '0);
    wait_drained();
    hit_mode = 1'b0;
    check_xfers(0, "hit");

    // store into the cached line, load right behind it
    store_mode = 1'b1;
    chk_addr = 32'h0000_0128;
    chk_data = $random(seed);
    chk_strb = 4'b0101;
    xfer_base = xfer_cnt;
    issue_req(1'b1, chk_addr, chk_data, chk_strb);
    issue_req(1'b0, chk_addr, '0, '0);
    wait_drained();
    check_xfers(1, "cached store");

    // store to an uncached line, the load behind it refills
    chk_addr = 32'h0000_0340;
    chk_data = $random(seed);
    chk_strb = 4'b1000;
    xfer_base = xfer_cnt;
    issue_req(1'b1, chk_addr, chk_data, chk_strb);
    issue_req(1'b0, chk_addr, '0, '0);
    wait_drained();
    check_xfers(5, "uncached store");
    store_mode = 1'b0;

    // random stream over the 256-word window
    for (int n = 0; n < RANDOM_OPS; n++) begin
      rnd = $random(seed);
      ctl = $random(seed);
      addr = {22'h0, rnd[7:0], 2'b00};
      issue_req(ctl[0], addr, $random(seed), ctl[7:4]);
      if (ctl[9:8] == 2'b00) begin
        @(posedge clk);
        #1;
      end
    end
    wait_drained();

    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_match_a: assert (i_mem.mem[i] === ref_mem[i])
        else begin
          errors++;
          $display("FAILED mem[%0d] exp %h got %h", i, ref_mem[i], i_mem.mem[i]);
        end
    end
    end_run();
  end

endmodule

//--- test/tb_apb_mem.sv
// APB completer memory for the data cache testbench
// each access phase gets zero to three random wait cycles
// the word array is read by the bench through the instance hierarchy
module tb_apb_mem #(
  parameter int          WORDS = 256,
  parameter logic [31:0] SEED  = 32'h1
) (
  input  logic        clk,
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  logic [31:0] paddr_i,
  input  logic [31:0] pwdata_i,
  input  logic [3:0]  pstrb_i,
  output logic        pready_o,
  output logic [31:0] prdata_o
);
  localparam int AW = $clog2(WORDS);

  logic [31:0] mem [WORDS];
  int seed;
  int wait_cnt;
  logic [AW-1:0] idx;

  // address bits above the window are ignored
  assign idx = paddr_i[AW+1:2];

  initial begin
    seed = SEED;
    wait_cnt = 0;
    pready_o = 1'b0;
    prdata_o = '0;
    // odd multiplier, so every address bit changes the word
    for (int i = 0; i < WORDS; i++) begin
      mem[i] = (i * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
    end
  end

  always @(posedge clk) begin : apb_seq
    int delay;
    if (psel_i && !penable_i) begin
      delay = {$random(seed)} % 4;
      wait_cnt <= delay;
      pready_o <= (delay == 0);
      prdata_o <= mem[idx];
    end else if (psel_i && penable_i && !pready_o) begin
      wait_cnt <= wait_cnt - 1;
      pready_o <= (wait_cnt == 1);
    end else begin
      pready_o <= 1'b0;
    end
    // strobed write at the end of the access phase
    if (psel_i && penable_i && pready_o && pwrite_i) begin
      for (int b = 0; b < 4; b++) begin
        if (pstrb_i[b]) begin
          mem[idx][8*b +: 8] <= pwdata_i[8*b +: 8];
        end
      end
    end
  end

endmodule

//--- source/dcache_top.sv
// top level of the data cache subsystem
// processor request/response port on one side, APB requester pins on the other
module dcache_top #(
  parameter int IDX_LEN = 8
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  dcache_pkg::cpu_req_t cpu_req_i,
  output logic                 cpu_ready_o,
  output dcache_pkg::cpu_rsp_t cpu_rsp_o,
  output logic                 psel_o,
  output logic                 penable_o,
  output logic                 pwrite_o,
  output logic [31:0]          paddr_o,
  output logic [31:0]          pwdata_o,
  output logic [3:0]           pstrb_o,
  input  logic                 pready_i,
  input  logic [31:0]          prdata_i
);
  import dcache_pkg::*;

  logic stall;
  cpu_req_t m1_req;
  dcache_tag_t m1_tag;
  logic [31:0] m1_data;
  dm_req_t dm_rd;
  dm_req_t dm_op;
  dm_req_t dm_req;
  dm_resp_t dm_resp;
  dm_snoop_t dm_snoop;
  mem_req_t mem_req;
  mem_rsp_t mem_rsp;

  assign cpu_ready_o = !stall;

  // read fields from EX, op fields from M2
  always_comb begin
    dm_req = dm_op;
    dm_req.rd_valid = dm_rd.rd_valid;
    dm_req.rd_addr = dm_rd.rd_addr;
  end

  lsu_m1_stage #(
    .IDX_LEN(IDX_LEN)
  ) i_m1 (
    .clk       (clk),
    .rst_n     (rst_n),
    .cpu_req_i (cpu_req_i),
    .stall_i   (stall),
    .dm_resp_i (dm_resp),
    .dm_snoop_i(dm_snoop),
    .dm_rd_o   (dm_rd),
    .m1_req_o  (m1_req),
    .m1_tag_o  (m1_tag),
    .m1_data_o (m1_data)
  );

  lsu_m2_stage #(
    .IDX_LEN(IDX_LEN)
  ) i_m2 (
    .clk       (clk),
    .rst_n     (rst_n),
    .m1_req_i  (m1_req),
    .m1_tag_i  (m1_tag),
    .m1_data_i (m1_data),
    .dm_resp_i (dm_resp),
    .dm_snoop_i(dm_snoop),
    .stall_o   (stall),
    .dm_op_o   (dm_op),
    .cpu_rsp_o (cpu_rsp_o)
  );

  dcache_manager #(
    .IDX_LEN(IDX_LEN)
  ) i_manager (
    .clk       (clk),
    .rst_n     (rst_n),
    .dm_req_i  (dm_req),
    .mem_rsp_i (mem_rsp),
    .dm_resp_o (dm_resp),
    .dm_snoop_o(dm_snoop),
    .mem_req_o (mem_req)
  );

  apb_mem_requester i_apb (
    .clk      (clk),
    .rst_n    (rst_n),
    .mem_req_i(mem_req),
    .pready_i (pready_i),
    .prdata_i (prdata_i),
    .mem_rsp_o(mem_rsp),
    .psel_o   (psel_o),
    .penable_o(penable_o),
    .pwrite_o (pwrite_o),
    .paddr_o  (paddr_o),
    .pwdata_o (pwdata_o),
    .pstrb_o  (pstrb_o)
  );

endmodule

//--- source/apb_mem_requester.sv
// APB requester for the cache's memory port
// one manager transfer becomes one setup phase and one or more access cycles
module apb_mem_requester (
  input  logic                 clk,
  input  logic                 rst_n,
  input  dcache_pkg::mem_req_t mem_req_i,
  input  logic                 pready_i,
  input  logic [31:0]          prdata_i,
  output dcache_pkg::mem_rsp_t mem_rsp_o,
  output logic                 psel_o,
  output logic                 penable_o,
  output logic                 pwrite_o,
  output logic [31:0]          paddr_o,
  output logic [31:0]          pwdata_o,
  output logic [3:0]           pstrb_o
);
  import dcache_pkg::*;

  typedef enum logic [1:0] {
    APB_IDLE,
    APB_SETUP,
    APB_ACCESS
  } apb_state_e;

  apb_state_e state_q;
  mem_req_t req_q;

  // always back through IDLE, so transfers are one cycle apart at least
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= APB_IDLE;
    end else begin
      case (state_q)
        APB_IDLE: begin
          if (mem_req_i.valid) begin
            state_q <= APB_SETUP;
          end
        end
        APB_SETUP: state_q <= APB_ACCESS;
        APB_ACCESS: begin
          if (pready_i) begin
            state_q <= APB_IDLE;
          end
        end
        default: state_q <= APB_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == APB_IDLE && mem_req_i.valid) begin
      req_q <= mem_req_i;
    end
  end

  assign psel_o = state_q != APB_IDLE;
  assign penable_o = state_q == APB_ACCESS;
  assign pwrite_o = req_q.write;
  assign paddr_o = req_q.addr;
  assign pwdata_o = req_q.wdata;
  assign pstrb_o = req_q.strb;

  assign mem_rsp_o.done = (state_q == APB_ACCESS) && pready_i;
  assign mem_rsp_o.rdata = prdata_i;

  // the latched transfer still matches the manager's request on the bus
  bus_matches_req_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    psel_o |-> mem_req_i.valid && mem_req_i == req_q
  );

endmodule

//--- source/dcache_manager.sv
// cache manager, sole owner of the tag and data arrays
// serves the pipeline's registered read port, broadcasts every array write
// and sequences line refills and write-through stores over the memory port
module dcache_manager #(
  parameter int IDX_LEN = 8
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  dcache_pkg::dm_req_t   dm_req_i,
  input  dcache_pkg::mem_rsp_t  mem_rsp_i,
  output dcache_pkg::dm_resp_t  dm_resp_o,
  output dcache_pkg::dm_snoop_t dm_snoop_o,
  output dcache_pkg::mem_req_t  mem_req_o
);
  import dcache_pkg::*;

  localparam int LINES = 2 ** IDX_LEN;
  localparam int WORD_BITS = $clog2(LINE_WORDS);

  logic [LINES-1:0] tag_valid_q;
  logic [TAG_LEN-1:0] tag_addr_q [LINES];
  logic [31:0] data_arr_q [LINES*LINE_WORDS];

  dcache_tag_t rd_tag_q;
  logic [31:0] rd_data_q;
  logic rd_valid_q;

  mgr_state_e state_q;
  logic [31:0] addr_q;
  logic [31:0] wdata_q;
  logic [3:0] strb_q;
  logic [WORD_BITS-1:0] word_q;
  logic [31:0] load_word_q;

  logic [IDX_LEN-1:0] rd_line;
  logic [IDX_LEN+WORD_BITS-1:0] rd_word;
  logic [IDX_LEN-1:0] wr_line;
  logic [IDX_LEN+WORD_BITS-1:0] wr_word;
  logic [IDX_LEN-1:0] op_line;
  logic [IDX_LEN+WORD_BITS-1:0] op_word;
  dcache_tag_t op_tag;

  assign rd_line = dm_req_i.rd_addr[IDX_LEN+3:4];
  assign rd_word = dm_req_i.rd_addr[IDX_LEN+3:2];
  assign wr_line = dm_snoop_o.tag_idx[IDX_LEN-1:0];
  assign wr_word = dm_snoop_o.data_idx[IDX_LEN+WORD_BITS-1:0];
  assign op_line = addr_q[IDX_LEN+3:4];
  assign op_word = addr_q[IDX_LEN+3:2];
  assign op_tag = '{valid: tag_valid_q[op_line], addr: tag_addr_q[op_line]};

  // read port, a write in the same cycle is forwarded
  always_ff @(posedge clk) begin
    if (dm_snoop_o.tag_we && wr_line == rd_line) begin
      rd_tag_q <= dm_snoop_o.tag_data;
    end else begin
      rd_tag_q <= '{valid: tag_valid_q[rd_line], addr: tag_addr_q[rd_line]};
    end
    if (dm_snoop_o.data_we && wr_word == rd_word) begin
      rd_data_q <= dm_snoop_o.data_word;
    end else begin
      rd_data_q <= data_arr_q[rd_word];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_valid_q <= 1'b0;
      tag_valid_q <= '0;
    end else begin
      rd_valid_q <= dm_req_i.rd_valid;
      if (dm_snoop_o.tag_we) begin
        tag_valid_q[wr_line] <= dm_snoop_o.tag_data.valid;
      end
    end
  end

  // arrays are written only from the snoop fields
  always_ff @(posedge clk) begin
    if (dm_snoop_o.tag_we) begin
      tag_addr_q[wr_line] <= dm_snoop_o.tag_data.addr;
    end
    if (dm_snoop_o.data_we) begin
      data_arr_q[wr_word] <= dm_snoop_o.data_word;
    end
  end

  always_comb begin
    dm_snoop_o = '0;
    if (state_q == MGR_FILL && mem_rsp_i.done) begin
      dm_snoop_o.data_we = 1'b1;
      dm_snoop_o.data_idx = {addr_q[31:4], word_q};
      dm_snoop_o.data_word = mem_rsp_i.rdata;
      // tag goes valid with the last word of the line
      if (word_q == WORD_BITS'(LINE_WORDS - 1)) begin
        dm_snoop_o.tag_we = 1'b1;
        dm_snoop_o.tag_idx = addr_q[31:4];
        dm_snoop_o.tag_data = '{valid: 1'b1, addr: addr_q[31:4]};
      end
    end
    if (state_q == MGR_WRITE && mem_rsp_i.done && cache_hit(op_tag, addr_q)) begin
      dm_snoop_o.data_we = 1'b1;
      dm_snoop_o.data_idx = addr_q[31:2];
      dm_snoop_o.data_word = strb_merge(data_arr_q[op_word], wdata_q, strb_q);
    end
  end

  always_comb begin
    mem_req_o.valid = (state_q == MGR_FILL) || (state_q == MGR_WRITE);
    mem_req_o.write = state_q == MGR_WRITE;
    mem_req_o.addr = (state_q == MGR_WRITE) ? addr_q : {addr_q[31:4], word_q, 2'b00};
    mem_req_o.wdata = wdata_q;
    mem_req_o.strb = strb_q;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= MGR_IDLE;
      word_q <= '0;
    end else begin
      case (state_q)
        MGR_IDLE: begin
          word_q <= '0;
          if (dm_req_i.op_valid && dm_req_i.op == OP_REFILL) begin
            state_q <= MGR_FILL;
          end else if (dm_req_i.op_valid && dm_req_i.op == OP_STORE) begin
            state_q <= MGR_WRITE;
          end
        end
        MGR_FILL: begin
          if (mem_rsp_i.done) begin
            word_q <= word_q + 1'b1;
            if (word_q == WORD_BITS'(LINE_WORDS - 1)) begin
              state_q <= MGR_DONE;
            end
          end
        end
        MGR_WRITE: begin
          if (mem_rsp_i.done) begin
            state_q <= MGR_DONE;
          end
        end
        default: state_q <= MGR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == MGR_IDLE && dm_req_i.op_valid) begin
      addr_q <= dm_req_i.op_addr;
      wdata_q <= dm_req_i.op_wdata;
      strb_q <= dm_req_i.op_strb;
    end
    // keep the word the load asked for
    if (state_q == MGR_FILL && mem_rsp_i.done && word_q == addr_q[3:2]) begin
      load_word_q <= mem_rsp_i.rdata;
    end
  end

  always_comb begin
    dm_resp_o.tag = rd_tag_q;
    dm_resp_o.rdata = rd_data_q;
    dm_resp_o.rdata_valid = rd_valid_q;
    dm_resp_o.op_ready = state_q == MGR_IDLE;
    dm_resp_o.op_done = state_q == MGR_DONE;
    dm_resp_o.op_rdata = load_word_q;
  end

  // the memory port only completes a transfer that was requested
  mem_done_has_req_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    mem_rsp_i.done |-> mem_req_o.valid
  );

endmodule

//--- source/lsu_m2_stage.sv
// M2 stage of the load/store pipeline
// completes load hits directly, hands misses and stores to the cache manager
// and holds the pipeline until the manager reports completion
module lsu_m2_stage #(
  parameter int IDX_LEN = 8
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  dcache_pkg::cpu_req_t    m1_req_i,
  input  dcache_pkg::dcache_tag_t m1_tag_i,
  input  logic [31:0]             m1_data_i,
  input  dcache_pkg::dm_resp_t    dm_resp_i,
  input  dcache_pkg::dm_snoop_t   dm_snoop_i,
  output logic                    stall_o,
  output dcache_pkg::dm_req_t     dm_op_o,
  output dcache_pkg::cpu_rsp_t    cpu_rsp_o
);
  import dcache_pkg::*;

  m2_state_e state_q;
  logic m2_valid_q;
  cpu_req_t m2_req_q;
  logic hit_q;
  logic [31:0] data_q;
  logic need_op;
  logic [IDX_LEN-1:0] m2_line;

  assign m2_line = m2_req_q.addr[IDX_LEN+3:4];
  // stores always go to the manager, loads only on a miss
  assign need_op = m2_valid_q && (m2_req_q.write || !hit_q);
  assign stall_o = (state_q != M2_IDLE) || need_op;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= M2_IDLE;
      m2_valid_q <= 1'b0;
    end else begin
      case (state_q)
        M2_IDLE: begin
          if (need_op) begin
            state_q <= M2_ISSUE;
          end else begin
            m2_valid_q <= m1_req_i.valid;
          end
        end
        M2_ISSUE: begin
          if (dm_resp_i.op_ready) begin
            state_q <= M2_WAIT;
          end
        end
        M2_WAIT: begin
          if (dm_resp_i.op_done) begin
            state_q <= M2_IDLE;
            m2_valid_q <= 1'b0;
          end
        end
        default: state_q <= M2_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_o) begin
      m2_req_q <= m1_req_i;
      hit_q <= cache_hit(m1_tag_i, m1_req_i.addr);
      data_q <= m1_data_i;
    end else if (dm_snoop_i.tag_we && dm_snoop_i.tag_idx[IDX_LEN-1:0] == m2_line) begin
      // tag replaced under a waiting item
      hit_q <= cache_hit(dm_snoop_i.tag_data, m2_req_q.addr);
    end
  end

  always_comb begin
    dm_op_o = '0;
    dm_op_o.op_valid = state_q == M2_ISSUE;
    dm_op_o.op = OP_NONE;
    if (state_q == M2_ISSUE) begin
      dm_op_o.op = m2_req_q.write ? OP_STORE : OP_REFILL;
    end
    dm_op_o.op_addr = m2_req_q.addr;
    dm_op_o.op_wdata = m2_req_q.wdata;
    dm_op_o.op_strb = m2_req_q.strb;
  end

  always_comb begin
    cpu_rsp_o.valid = 1'b0;
    cpu_rsp_o.rdata = '0;
    if (state_q == M2_IDLE && m2_valid_q && !need_op) begin
      cpu_rsp_o.valid = 1'b1;
      cpu_rsp_o.rdata = data_q;
    end else if (state_q == M2_WAIT && dm_resp_i.op_done) begin
      cpu_rsp_o.valid = 1'b1;
      // stores answer with zero
      cpu_rsp_o.rdata = m2_req_q.write ? '0 : dm_resp_i.op_rdata;
    end
  end

  // completion only arrives for an operation that was handed over
  done_only_when_waiting_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    dm_resp_i.op_done |-> state_q == M2_WAIT
  );

endmodule

//--- source/lsu_m1_stage.sv
// EX and M1 stages of the load/store pipeline
// EX sends the array read, M1 captures tag and data and keeps them current
// through the manager's snoop broadcast while the pipeline is stalled
module lsu_m1_stage #(
  parameter int IDX_LEN = 8
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  dcache_pkg::cpu_req_t    cpu_req_i,
  input  logic                    stall_i,
  input  dcache_pkg::dm_resp_t    dm_resp_i,
  input  dcache_pkg::dm_snoop_t   dm_snoop_i,
  output dcache_pkg::dm_req_t     dm_rd_o,
  output dcache_pkg::cpu_req_t    m1_req_o,
  output dcache_pkg::dcache_tag_t m1_tag_o,
  output logic [31:0]             m1_data_o
);
  import dcache_pkg::*;

  logic accept;
  logic m1_valid_q;
  cpu_req_t m1_req_q;
  dcache_tag_t tag_q;
  logic [31:0] data_q;
  logic [IDX_LEN-1:0] m1_line;
  logic [IDX_LEN+1:0] m1_word;

  // EX stage, plain wiring to the read port
  assign accept = cpu_req_i.valid && !stall_i;

  always_comb begin
    dm_rd_o = '0;
    dm_rd_o.rd_valid = accept;
    dm_rd_o.rd_addr = cpu_req_i.addr;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      m1_valid_q <= 1'b0;
    end else if (!stall_i) begin
      m1_valid_q <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      m1_req_q <= cpu_req_i;
    end
  end

  assign m1_line = m1_req_q.addr[IDX_LEN+3:4];
  assign m1_word = m1_req_q.addr[IDX_LEN+3:2];

  always_comb begin
    // fresh read in the first M1 cycle, held copy afterwards
    m1_tag_o = dm_resp_i.rdata_valid ? dm_resp_i.tag : tag_q;
    m1_data_o = dm_resp_i.rdata_valid ? dm_resp_i.rdata : data_q;
    // array writes in flight override what was read
    if (dm_snoop_i.tag_we && dm_snoop_i.tag_idx[IDX_LEN-1:0] == m1_line) begin
      m1_tag_o = dm_snoop_i.tag_data;
    end
    if (dm_snoop_i.data_we && dm_snoop_i.data_idx[IDX_LEN+1:0] == m1_word) begin
      m1_data_o = dm_snoop_i.data_word;
    end
  end

  always_ff @(posedge clk) begin
    tag_q <= m1_tag_o;
    data_q <= m1_data_o;
  end

  always_comb begin
    m1_req_o = m1_req_q;
    m1_req_o.valid = m1_valid_q;
  end

  // the manager answers every EX read in the first M1 cycle
  read_returns_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    dm_rd_o.rd_valid |=> dm_resp_i.rdata_valid && m1_valid_q
  );

endmodule

//--- source/dcache_pkg.sv
// shared types of the direct-mapped write-through data cache
// pipeline stages, cache manager and memory port all import this package
package dcache_pkg;

  // tag is the whole line address, independent of the index width
  localparam int TAG_LEN = 28;
  localparam int LINE_WORDS = 4;

  typedef struct packed {
    logic valid;
    logic [TAG_LEN-1:0] addr;
  } dcache_tag_t;

  typedef struct packed {
    logic valid;
    logic write;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0] strb;
  } cpu_req_t;

  typedef struct packed {
    logic valid;
    logic [31:0] rdata;
  } cpu_rsp_t;

  typedef enum logic [1:0] {
    OP_NONE,
    OP_REFILL,
    OP_STORE
  } dm_op_e;

  // read fields come from EX, op fields from M2
  typedef struct packed {
    logic rd_valid;
    logic [31:0] rd_addr;
    logic op_valid;
    dm_op_e op;
    logic [31:0] op_addr;
    logic [31:0] op_wdata;
    logic [3:0] op_strb;
  } dm_req_t;

  typedef struct packed {
    dcache_tag_t tag;
    logic [31:0] rdata;
    logic rdata_valid;
    logic op_ready;
    logic op_done;
    logic [31:0] op_rdata;
  } dm_resp_t;

  // indices carry the full line / word address, receivers compare the low bits
  typedef struct packed {
    logic tag_we;
    logic [TAG_LEN-1:0] tag_idx;
    dcache_tag_t tag_data;
    logic data_we;
    logic [TAG_LEN+1:0] data_idx;
    logic [31:0] data_word;
  } dm_snoop_t;

  typedef enum logic [1:0] {
    M2_IDLE,
    M2_ISSUE,
    M2_WAIT
  } m2_state_e;

  typedef enum logic [1:0] {
    MGR_IDLE,
    MGR_FILL,
    MGR_WRITE,
    MGR_DONE
  } mgr_state_e;

  typedef struct packed {
    logic valid;
    logic write;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0] strb;
  } mem_req_t;

  typedef struct packed {
    logic done;
    logic [31:0] rdata;
  } mem_rsp_t;

  function automatic logic cache_hit(dcache_tag_t tag, logic [31:0] addr);
    return tag.valid && (tag.addr == addr[31:32-TAG_LEN]);
  endfunction

  // byte lanes with strobe set take the new word
  function automatic logic [31:0] strb_merge(logic [31:0] old_word,
                                             logic [31:0] new_word,
                                             logic [3:0] strb);
    logic [31:0] merged;
    for (int i = 0; i < 4; i++) begin
      merged[8*i +: 8] = strb[i] ? new_word[8*i +: 8] : old_word[8*i +: 8];
    end
    return merged;
  endfunction

endpackage
